/* Bender.yml */
package:
  name: ac97_audio

sources:
  - include_dirs:
      - hw
    files:
      - hw/audio_pkg.sv
      - hw/button_debounce.sv
      - hw/volume_control.sv
      - hw/codec_cmd_seq.sv
      - hw/ac97_frame.sv
      - hw/ac97_link.sv
      - hw/ac97_audio_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/ac97_audio_asserts.sv
      - sim/ac97_audio_tb.sv

/* ac97_audio_top.f */
+incdir+hw
hw/audio_pkg.sv
hw/button_debounce.sv
hw/volume_control.sv
hw/codec_cmd_seq.sv
hw/ac97_frame.sv
hw/ac97_link.sv
hw/ac97_audio_top.sv
sim/ac97_audio_asserts.sv
sim/ac97_audio_tb.sv

/* hw/ac97_audio_top.sv */
`include "audio_defs.svh"

module ac97_audio_top import audio_pkg::*; #(
  parameter int debounce_cycles = `AUDIO_DEBOUNCE_CYCLES
) (
  input  logic                       clock_27mhz,
  input  logic                       reset,
  input  logic                       button_up,       // active low
  input  logic                       button_down,     // active low
  output volume_t                    volume,
  input  logic [`AUDIO_SAMPLE_W-1:0] audio_out_data,  // taken on ready
  output logic [`AUDIO_SAMPLE_W-1:0] audio_in_data,
  output logic                       ready,
  output logic                       audio_reset_b,   // codec pins
  output logic                       ac97_synch,
  output logic                       ac97_sdata_out,
  input  logic                       ac97_sdata_in,
  input  logic                       ac97_bit_clock
);

  volume_control #(.debounce_cycles(debounce_cycles)) u_volume_control (
    .clock_27mhz (clock_27mhz),
    .reset       (reset),
    .button_up   (button_up),
    .button_down (button_down),
    .volume      (volume)
  );

  ac97_link u_ac97_link (
    .clock_27mhz    (clock_27mhz),
    .reset          (reset),
    .volume         (volume),
    .audio_out_data (audio_out_data),
    .audio_in_data  (audio_in_data),
    .ready          (ready),
    .audio_reset_b  (audio_reset_b),
    .ac97_synch     (ac97_synch),
    .ac97_sdata_out (ac97_sdata_out),
    .ac97_sdata_in  (ac97_sdata_in),
    .ac97_bit_clock (ac97_bit_clock)
  );

endmodule

/* hw/ac97_frame.sv */
`include "audio_defs.svh"

module ac97_frame import audio_pkg::*; (
  input  logic                       reset,
  input  logic                       ac97_bit_clock,
  input  ac97_cmd_t                  cmd,
  input  logic [`AUDIO_SAMPLE_W-1:0] play_sample,
  output logic                       frame_ready,
  output logic [`AUDIO_SAMPLE_W-1:0] audio_in_data,
  output logic                       ac97_synch,
  output logic                       ac97_sdata_out,
  input  logic                       ac97_sdata_in
);

  localparam int CNT_W = $clog2(`AC97_FRAME_LAST + 1);  // 9 bits
  localparam int IDX_W = $clog2(`AC97_SLOT_W);          // bit within a slot

  logic [1:0]                 rst_sync;
  logic                       frame_reset;
  logic [CNT_W-1:0]           bit_count;

  // frame latch, loaded once at the last bit
  ac97_cmd_t                  l_cmd;
  logic [`AUDIO_SAMPLE_W-1:0] l_sample;
  logic                       l_pcm_v;     // left and right tags

  logic [`AC97_SLOT_W-1:0]    slot_addr, slot_data, slot_pcm;
  logic                       tx_bit;
  logic [`AC97_SLOT_W-1:0]    in_shift;    // slot 3 from the codec

  ////////////////////////////////////////////////////////////
  // reset into the bit clock domain
  ////////////////////////////////////////////////////////////
  always_ff @(posedge ac97_bit_clock) begin
    rst_sync <= {rst_sync[0], reset};
  end
  assign frame_reset = rst_sync[1];

  // left justify everything in 20 bit slots
  assign slot_addr = {l_cmd.addr, {(`AC97_SLOT_W - `CODEC_ADDR_W){1'b0}}};
  assign slot_data = {l_cmd.data.raw, {(`AC97_SLOT_W - `CODEC_DATA_W){1'b0}}};
  assign slot_pcm  = {l_sample, {(`AC97_SLOT_W - `AUDIO_SAMPLE_W){1'b0}}};

  ////////////////////////////////////////////////////////////
  // slot mux, msb first
  ////////////////////////////////////////////////////////////
  always_comb begin
    tx_bit = 1'b0;
    if (bit_count < `AC97_SLOT1_START) begin
      case (bit_count[3:0])                // slot 0 tags
        4'd0:       tx_bit = 1'b1;         // frame valid
        4'd1, 4'd2: tx_bit = l_cmd.valid;  // addr and data valid
        4'd3, 4'd4: tx_bit = l_pcm_v;      // left and right valid
        default:    tx_bit = 1'b0;
      endcase
    end else if (bit_count < `AC97_SLOT2_START) begin
      tx_bit = l_cmd.valid & slot_addr[IDX_W'(`AC97_SLOT2_START - 1 - bit_count)];
    end else if (bit_count < `AC97_SLOT3_START) begin
      tx_bit = l_cmd.valid & slot_data[IDX_W'(`AC97_SLOT3_START - 1 - bit_count)];
    end else if (bit_count < `AC97_SLOT4_START) begin
      tx_bit = l_pcm_v & slot_pcm[IDX_W'(`AC97_SLOT4_START - 1 - bit_count)];
    end else if (bit_count < `AC97_SLOT4_START + `AC97_SLOT_W) begin
      // right slot repeats the left sample
      tx_bit = l_pcm_v &
               slot_pcm[IDX_W'(`AC97_SLOT4_START + `AC97_SLOT_W - 1 - bit_count)];
    end
  end

  always_ff @(posedge ac97_bit_clock) begin
    if (frame_reset) begin
      bit_count      <= '0;
      ac97_synch     <= 1'b0;
      ac97_sdata_out <= 1'b0;
      frame_ready    <= 1'b0;
      l_cmd.valid    <= 1'b0;   // first frame goes out empty
      l_pcm_v        <= 1'b0;
    end else begin
      bit_count      <= bit_count + 1'b1;  // rolls 511 -> 0
      ac97_sdata_out <= tx_bit;

      if (bit_count == CNT_W'(`AC97_FRAME_LAST)) begin
        ac97_synch <= 1'b1;
        l_cmd      <= cmd;
        l_sample   <= play_sample;
        l_pcm_v    <= 1'b1;
      end else if (bit_count == CNT_W'(`AC97_SYNC_END)) begin
        ac97_synch <= 1'b0;
      end

      // level for the 27 MHz side, spans the frame boundary
      if (bit_count == CNT_W'(`AC97_READY_SET))
        frame_ready <= 1'b1;
      else if (bit_count == CNT_W'(`AC97_READY_CLR))
        frame_ready <= 1'b0;
    end
  end

  // codec drives on rising edge, sample on falling
  always_ff @(negedge ac97_bit_clock) begin
    if (bit_count > `AC97_SLOT3_START && bit_count <= `AC97_SLOT4_START)
      in_shift <= {in_shift[`AC97_SLOT_W-2:0], ac97_sdata_in};
  end

  assign audio_in_data = in_shift[`AC97_SLOT_W-1 -: `AUDIO_SAMPLE_W];

endmodule

/* hw/ac97_link.sv */
`include "audio_defs.svh"

module ac97_link import audio_pkg::*; (
  input  logic                       clock_27mhz,
  input  logic                       reset,
  input  volume_t                    volume,
  input  logic [`AUDIO_SAMPLE_W-1:0] audio_out_data,
  output logic [`AUDIO_SAMPLE_W-1:0] audio_in_data,
  output logic                       ready,
  output logic                       audio_reset_b,
  output logic                       ac97_synch,
  output logic                       ac97_sdata_out,
  input  logic                       ac97_sdata_in,
  input  logic                       ac97_bit_clock
);

  localparam int RST_CNT_W = $clog2(`CODEC_RESET_CYCLES);  // 10 bits

  logic [RST_CNT_W-1:0]       reset_count;
  logic [2:0]                 ready_sync;
  logic                       frame_ready;   // bit clock domain level
  logic [`AUDIO_SAMPLE_W-1:0] play_sample;
  ac97_cmd_t                  cmd;

  // hold the codec in reset a while after ours ends
  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      audio_reset_b <= 1'b0;
      reset_count   <= '0;
    end else if (reset_count == RST_CNT_W'(`CODEC_RESET_CYCLES - 1)) begin
      audio_reset_b <= 1'b1;
    end else begin
      reset_count <= reset_count + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // frame_ready into clock_27mhz, one pulse per frame
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clock_27mhz) begin
    if (reset)
      ready_sync <= '0;
    else
      ready_sync <= {ready_sync[1:0], frame_ready};
  end
  assign ready = ready_sync[1] & ~ready_sync[2];  // rising edge

  // sample stays put until the frame latch picks it up
  always_ff @(posedge clock_27mhz) begin
    if (ready)
      play_sample <= audio_out_data;
  end

  ac97_frame u_ac97_frame (
    .reset          (reset),
    .ac97_bit_clock (ac97_bit_clock),
    .cmd            (cmd),
    .play_sample    (play_sample),
    .frame_ready    (frame_ready),
    .audio_in_data  (audio_in_data),
    .ac97_synch     (ac97_synch),
    .ac97_sdata_out (ac97_sdata_out),
    .ac97_sdata_in  (ac97_sdata_in)
  );

  codec_cmd_seq u_codec_cmd_seq (
    .clock_27mhz (clock_27mhz),
    .reset       (reset),
    .ready       (ready),
    .volume      (volume),
    .cmd         (cmd)
  );

endmodule

/* hw/audio_defs.svh */
`ifndef AUDIO_DEFS_SVH
`define AUDIO_DEFS_SVH

////////////////////////////////////////////////////////////
// ac97 frame layout, counted in bit clocks
////////////////////////////////////////////////////////////
`define AUDIO_SAMPLE_W        12      // playback / record sample
`define AC97_SLOT_W           20      // data bits per slot
`define AC97_FRAME_LAST       511     // 512 bits per frame
`define AC97_SYNC_END         15      // sync covers the tag slot
`define AC97_READY_SET        256
`define AC97_READY_CLR        2
`define AC97_SLOT1_START      16      // command address
`define AC97_SLOT2_START      36      // command data
`define AC97_SLOT3_START      56      // pcm left
`define AC97_SLOT4_START      76      // pcm right

// link timing, in clock_27mhz cycles
`define CODEC_RESET_CYCLES    1024
`define AUDIO_DEBOUNCE_CYCLES 270000  // about 10 ms

// volume knob
`define VOLUME_W              5
`define VOLUME_MAX            31
`define VOLUME_MIN            0
`define VOLUME_RESET          8

////////////////////////////////////////////////////////////
// codec registers and the fixed words written to them
////////////////////////////////////////////////////////////
`define CODEC_ADDR_W          8
`define CODEC_DATA_W          16
`define REC_SOURCE_MIC        0       // record select code for mic
`define CODEC_REG_READ_ID     8'h80   // read bit + reset register
`define CODEC_REG_HP_VOL      8'h04
`define CODEC_REG_PCM_VOL     8'h18
`define CODEC_PCM_VOL_DATA    16'h0808 // 0 dB both sides
`define CODEC_REG_REC_SEL     8'h1A
`define CODEC_REG_REC_GAIN    8'h1C
`define CODEC_REC_GAIN_DATA   16'h0F0F // max gain
`define CODEC_REG_MIC_VOL     8'h0E
`define CODEC_MIC_VOL_DATA    16'h8048 // +20 dB boost
`define CODEC_REG_BEEP_VOL    8'h0A
`define CODEC_BEEP_VOL_DATA   16'h0000
`define CODEC_REG_GEN_PURP    8'h20
`define CODEC_GEN_PURP_DATA   16'h8000 // pcm out bypasses 3d

`endif

/* hw/audio_pkg.sv */
`include "audio_defs.svh"

package audio_pkg;

  ////////////////////////////////////////////////////////////
  // shared types for the ac97 link
  ////////////////////////////////////////////////////////////

  typedef logic [`VOLUME_W-1:0] volume_t;  // 0 quiet .. 31 loud

  // mixer registers keep left in the high byte, right in the low
  typedef struct packed {
    logic [7:0] left;
    logic [7:0] right;
  } mixer_stereo_t;

  // same 16 bits, either a plain word or split per channel
  typedef union packed {
    logic [`CODEC_DATA_W-1:0] raw;
    mixer_stereo_t            stereo;
  } mixer_data_u;

  // one codec register access, sent in slots 1 and 2
  typedef struct packed {
    logic [`CODEC_ADDR_W-1:0] addr;   // bit 7 set means read
    mixer_data_u              data;
    logic                     valid;  // drives both command tags
  } ac97_cmd_t;

endpackage

/* hw/button_debounce.sv */
`include "audio_defs.svh"

module button_debounce #(
  parameter int debounce_cycles = `AUDIO_DEBOUNCE_CYCLES
) (
  input  logic clock_27mhz,
  input  logic reset,
  input  logic noisy,
  output logic clean
);

  localparam int CNT_W = $clog2(debounce_cycles + 1);

  logic [CNT_W-1:0] count;   // stable cycles so far
  logic             last;    // last sampled input

  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      count <= '0;
      last  <= noisy;        // start out agreeing with the pin
      clean <= noisy;
    end else if (noisy != last) begin
      // bounce, start timing again
      last  <= noisy;
      count <= '0;
    end else if (count == CNT_W'(debounce_cycles)) begin
      clean <= last;         // held long enough
    end else begin
      count <= count + 1'b1;
    end
  end

endmodule

/* hw/codec_cmd_seq.sv */
`include "audio_defs.svh"

module codec_cmd_seq import audio_pkg::*; (
  input  logic      clock_27mhz,
  input  logic      reset,
  input  logic      ready,     // one pulse per frame
  input  volume_t   volume,
  output ac97_cmd_t cmd
);

  logic [3:0]               state;      // one command per frame, wraps at 15
  volume_t                  atten;
  logic [`CODEC_ADDR_W-1:0] next_addr;
  mixer_data_u              next_data;

  // codec wants attenuation, 0 is loudest
  assign atten = volume_t'(`VOLUME_MAX) - volume;

  ////////////////////////////////////////////////////////////
  // command table
  ////////////////////////////////////////////////////////////
  always_comb begin
    next_addr     = `CODEC_REG_READ_ID;   // idle slots just read the id
    next_data.raw = '0;
    case (state)
      4'd3: begin                         // headphone volume
        next_addr              = `CODEC_REG_HP_VOL;
        next_data.stereo.left  = 8'(atten);
        next_data.stereo.right = 8'(atten);
      end
      4'd5: begin
        next_addr     = `CODEC_REG_PCM_VOL;
        next_data.raw = `CODEC_PCM_VOL_DATA;
      end
      4'd6: begin                         // record from mic, both sides
        next_addr              = `CODEC_REG_REC_SEL;
        next_data.stereo.left  = 8'(`REC_SOURCE_MIC);
        next_data.stereo.right = 8'(`REC_SOURCE_MIC);
      end
      4'd7: begin
        next_addr     = `CODEC_REG_REC_GAIN;
        next_data.raw = `CODEC_REC_GAIN_DATA;
      end
      4'd9: begin
        next_addr     = `CODEC_REG_MIC_VOL;
        next_data.raw = `CODEC_MIC_VOL_DATA;
      end
      4'd10: begin
        next_addr     = `CODEC_REG_BEEP_VOL;
        next_data.raw = `CODEC_BEEP_VOL_DATA;
      end
      4'd11: begin
        next_addr     = `CODEC_REG_GEN_PURP;
        next_data.raw = `CODEC_GEN_PURP_DATA;
      end
      default: ;                          // 0, 1 and the gaps: read id
    endcase
  end

  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      state     <= '0;
      cmd.valid <= 1'b0;
    end else begin
      if (ready)
        state <= state + 4'd1;
      cmd.valid <= 1'b1;                  // live from state 0 on
      cmd.addr  <= next_addr;             // one cycle behind state
      cmd.data  <= next_data;
    end
  end

endmodule

/* hw/volume_control.sv */
`include "audio_defs.svh"

module volume_control import audio_pkg::*; #(
  parameter int debounce_cycles = `AUDIO_DEBOUNCE_CYCLES
) (
  input  logic    clock_27mhz,
  input  logic    reset,
  input  logic    button_up,    // active low
  input  logic    button_down,  // active low
  output volume_t volume
);

  logic up_clean, down_clean;
  logic up_prev, down_prev;
  logic up_edge, down_edge;

  // buttons pull low when pressed
  button_debounce #(.debounce_cycles(debounce_cycles)) u_debounce_up (
    .clock_27mhz (clock_27mhz),
    .reset       (reset),
    .noisy       (~button_up),
    .clean       (up_clean)
  );

  button_debounce #(.debounce_cycles(debounce_cycles)) u_debounce_down (
    .clock_27mhz (clock_27mhz),
    .reset       (reset),
    .noisy       (~button_down),
    .clean       (down_clean)
  );

  assign up_edge   = up_clean & ~up_prev;     // press, not hold
  assign down_edge = down_clean & ~down_prev;

  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      up_prev   <= 1'b0;
      down_prev <= 1'b0;
      volume    <= volume_t'(`VOLUME_RESET);
    end else begin
      up_prev   <= up_clean;
      down_prev <= down_clean;
      // saturate at both ends, up wins a tie
      if (up_edge && volume != volume_t'(`VOLUME_MAX))
        volume <= volume + 1'b1;
      else if (down_edge && volume != volume_t'(`VOLUME_MIN))
        volume <= volume - 1'b1;
    end
  end

endmodule

/* sim/ac97_audio_asserts.sv */
module ac97_audio_asserts (
  input logic clock_27mhz,
  input logic reset,
  input logic ready,
  input logic audio_reset_b,
  input logic ac97_synch,
  input logic ac97_bit_clock
);

  int fail_count = 0;   // summed into the final result

  ////////////////////////////////////////////////////////////
  // 27 MHz side
  ////////////////////////////////////////////////////////////
  ready_one_cycle: assert property (@(posedge clock_27mhz) disable iff (reset)
    ready |=> !ready)
    else begin
      fail_count++;
      $error("ready strobe lasted more than one cycle");
    end

  // codec reset only drops because of our reset
  codec_reset_held: assert property (@(posedge clock_27mhz)
    $fell(audio_reset_b) |-> $past(reset))
    else begin
      fail_count++;
      $error("audio_reset_b fell outside reset");
    end

  ////////////////////////////////////////////////////////////
  // bit clock side
  ////////////////////////////////////////////////////////////
  sync_width: assert property (@(posedge ac97_bit_clock) disable iff (reset)
    $rose(ac97_synch) |-> ac97_synch [*16] ##1 !ac97_synch)   // whole tag slot
    else begin
      fail_count++;
      $error("ac97_synch not high for 16 bit clocks");
    end

endmodule

/* sim/ac97_audio_tb.sv */
`include "audio_defs.svh"

module ac97_audio_tb;

  localparam int DEBOUNCE     = 16;
  localparam int PRESS_CYCLES = 4 * DEBOUNCE;   // hold and release, well past debounce
  localparam int FRAME_CYCLES = 512 * 20 / 8;   // one ac97 frame in 27 MHz cycles
  localparam int MAX_TESTS    = 32;

  logic                       clock_27mhz, ac97_bit_clock, reset;
  logic                       button_up, button_down;
  logic [`VOLUME_W-1:0]       volume;
  logic [`AUDIO_SAMPLE_W-1:0] audio_out_data, audio_in_data;
  logic                       ready, audio_reset_b;
  logic                       ac97_synch, ac97_sdata_out, ac97_sdata_in;

  logic [31:0] vectors [0:3*MAX_TESTS-1];   // kind, arg, expected per test
  int          n_tests, errors, limit, ready_count, vol_model, frame_count;
  int          bit_pos;                     // codec side copy of the frame counter
  logic        synch_q;
  logic [95:0] rx_shift, rx_frame;          // tags and slots 1 to 4, bit 0 on top
  logic [19:0] rec_word;                    // slot 3 sent by the codec

  ac97_audio_top #(.debounce_cycles(DEBOUNCE)) u_ac97_audio_top (.*);

  bind ac97_link ac97_audio_asserts u_link_asserts (.*);

  ////////////////////////////////////////////////////////////
  // clocks
  ////////////////////////////////////////////////////////////
  initial begin
    clock_27mhz = 1'b0;
    forever #4 clock_27mhz = ~clock_27mhz;
  end

  initial begin
    ac97_bit_clock = 1'b0;
    #3;                                     // bit clock edges never meet 27 MHz edges
    forever #10 ac97_bit_clock = ~ac97_bit_clock;
  end

  ////////////////////////////////////////////////////////////
  // codec model
  ////////////////////////////////////////////////////////////
  always @(negedge ac97_bit_clock) begin
    if (reset) begin
      bit_pos = 1000;                       // lost, wait for sync
    end else if (ac97_synch && !synch_q) begin
      bit_pos = 0;                          // tag bits follow one clock later
    end else begin
      bit_pos = bit_pos + 1;
      if (bit_pos <= 96)
        rx_shift = {rx_shift[94:0], ac97_sdata_out};
      if (bit_pos == 96) begin
        rx_frame    = rx_shift;
        frame_count = frame_count + 1;
      end
    end
    synch_q = ac97_synch;
  end

  // slot 3 out of the codec, msb first
  always @(posedge ac97_bit_clock) begin
    if (bit_pos + 1 > `AC97_SLOT3_START && bit_pos + 1 <= `AC97_SLOT4_START)
      ac97_sdata_in <= rec_word[`AC97_SLOT4_START - 1 - bit_pos];
    else
      ac97_sdata_in <= 1'b0;
  end

  always @(negedge clock_27mhz) begin
    if (reset)
      ready_count = 0;
    else if (ready)
      ready_count = ready_count + 1;        // equals the sequencer state mod 16
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    wait (limit > 0);
    while (cycles < limit) begin
      @(posedge clock_27mhz);
      cycles++;
    end
    $display("timeout: tests did not finish within %0d cycles", limit);
    $display("STATUS: FAIL");
    $finish;
  end

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors++;
    $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
  endtask

  task automatic wait_ready();
    do @(negedge clock_27mhz); while (ready !== 1'b1);
  endtask

  task automatic wait_frame();
    int start;
    start = frame_count;
    while (frame_count == start) @(negedge clock_27mhz);
  endtask

  task automatic press_button(input bit up);
    @(negedge clock_27mhz);
    if (up)
      button_up = 1'b0;                     // active low
    else
      button_down = 1'b0;
    repeat (PRESS_CYCLES) @(negedge clock_27mhz);
    button_up   = 1'b1;
    button_down = 1'b1;
    repeat (PRESS_CYCLES) @(negedge clock_27mhz);
  endtask

  // register address and data per sequencer state
  function automatic logic [23:0] cmd_for_state(input int state, input int vol);
    logic [7:0] att;
    att = 8'(`VOLUME_MAX - vol);
    case (state)
      3:       return {8'h04, att, att};    // headphone attenuation
      5:       return {8'h18, 16'h0808};
      6:       return {8'h1a, 16'h0000};    // mic in both bytes
      7:       return {8'h1c, 16'h0f0f};
      9:       return {8'h0e, 16'h8048};
      10:      return {8'h0a, 16'h0000};
      11:      return {8'h20, 16'h8000};
      default: return {8'h80, 16'h0000};    // read id
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////
  initial begin
    logic [31:0] kind, arg, exp;
    logic [23:0] want;
    int          cycles, state, errs_before, failed, assert_fails;
    reset = 1'b1;
    button_up = 1'b1;
    button_down = 1'b1;
    audio_out_data = '0;
    ac97_sdata_in = 1'b0;
    rec_word = '0;
    failed = 0;
    void'($urandom(32'h873a_121e));
    $readmemh("sim/ac97_audio_vectors.txt", vectors);
    while (n_tests < MAX_TESTS && vectors[3*n_tests] !== 32'hff &&
           vectors[3*n_tests] !== 'x)
      n_tests++;
    if (n_tests == 0) begin
      errors++;
      $display("no tests could be read from the vector file");
    end
    limit = (n_tests + 1) * 40 * FRAME_CYCLES;

    for (int t = 0; t < n_tests; t++) begin
      kind = vectors[3*t];
      arg  = vectors[3*t+1];
      exp  = vectors[3*t+2];
      errs_before = errors;
      case (kind[7:0])
        8'h00: begin                        // reset and codec reset delay
          @(negedge clock_27mhz);
          reset = 1'b1;
          repeat (10) @(negedge clock_27mhz);
          reset = 1'b0;
          vol_model = `VOLUME_RESET;
          if (ac97_synch !== 1'b0) report_mismatch("ac97_synch", ac97_synch, 0);
          if (ac97_sdata_out !== 1'b0) report_mismatch("ac97_sdata_out", ac97_sdata_out, 0);
          if (audio_reset_b !== 1'b0) report_mismatch("audio_reset_b", audio_reset_b, 0);
          cycles = 0;
          while (audio_reset_b !== 1'b1 && cycles < 2 * arg) begin
            @(negedge clock_27mhz);
            cycles++;
          end
          if (cycles != arg) report_mismatch("audio_reset_b delay", cycles, arg);
          if (volume !== exp[4:0]) report_mismatch("volume", volume, exp);
        end
        8'h01, 8'h02: begin                 // volume presses, 1 up, 2 down
          for (int i = 0; i < arg; i++) begin
            press_button(kind[7:0] == 8'h01);
            if (kind[7:0] == 8'h01 && vol_model < `VOLUME_MAX)
              vol_model++;
            if (kind[7:0] == 8'h02 && vol_model > `VOLUME_MIN)
              vol_model--;
            if (volume !== 5'(vol_model)) report_mismatch("volume", volume, vol_model);
          end
          if (volume !== exp[4:0]) report_mismatch("volume", volume, exp);
        end
        8'h03: begin                        // command per frame
          for (int f = 0; f < arg; f++) begin
            wait_frame();
            state = ready_count % 16;
            want  = cmd_for_state(state, vol_model);
            if (rx_frame[94:93] !== 2'b11) report_mismatch("command tags", rx_frame[94:93], 3);
            if (rx_frame[79:60] !== {want[23:16], 12'h0})
              report_mismatch("slot 1", rx_frame[79:60], {want[23:16], 12'h0});
            if (rx_frame[59:40] !== {want[15:0], 4'h0})
              report_mismatch("slot 2", rx_frame[59:40], {want[15:0], 4'h0});
            if (state == 3 && rx_frame[59:44] !== exp[15:0])
              report_mismatch("headphone volume", rx_frame[59:44], exp);
          end
        end
        8'h04: begin                        // playback
          @(negedge clock_27mhz);
          audio_out_data = arg[11:0];
          wait_ready();
          wait_frame();                     // latched at the end of this frame
          if (rx_frame[92:91] !== 2'b11) report_mismatch("pcm tags", rx_frame[92:91], 3);
          if (rx_frame[39:20] !== exp[19:0]) report_mismatch("slot 3", rx_frame[39:20], exp);
          if (rx_frame[19:0] !== exp[19:0]) report_mismatch("slot 4", rx_frame[19:0], exp);
        end
        8'h05: begin                        // record
          wait_ready();
          rec_word = {arg[11:0], 8'($urandom)};
          wait_ready();
          if (audio_in_data !== exp[11:0])
            report_mismatch("audio_in_data", audio_in_data, exp);
        end
        default: begin
          errors++;
          $display("test %0d has an unknown kind %h", t, kind);
        end
      endcase
      if (errors != errs_before)
        failed++;
      $display("test %0d kind %0h arg %0h: %s", t, kind, arg,
               (errors == errs_before) ? "ok" : "failed");
    end

    assert_fails = u_ac97_audio_top.u_ac97_link.u_link_asserts.fail_count;
    $display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
             n_tests, failed, errors, assert_fails);
    if (errors == 0 && assert_fails == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

/* sim/ac97_audio_vectors.txt */
// kind arg expected, all hex, one test per line, kind ff ends the list
// 0 reset: delay, volume  1 up / 2 down: presses, volume  3 commands: frames, hp data
// 4 playback: sample, slot value  5 record: slot 3 top bits, audio_in_data
00 00000400 00000008
03 00000010 00001717
04 00000abc 000abc00
05 00000123 00000123
01 00000003 0000000b
02 00000002 00000009
03 00000010 00001616
01 00000020 0000001f
03 00000010 00000000
02 00000028 00000000
03 00000010 00001f1f
01 00000005 00000005
04 00000fff 000fff00
04 00000001 00000100
05 00000fed 00000fed
05 00000800 00000800
00 00000400 00000008
03 00000010 00001717
ff 00000000 00000000
